//--- Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - src
    files:
      - src/id_pkg.sv
      - src/operand_if.sv
      - src/if_id_reg.sv
      - src/operand_read.sv
      - src/inst_decoder.sv
      - src/branch_unit.sv
      - src/id_stage.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/id_checker.sv
      - tests/tb_id_stage.sv

//--- sim.f
+incdir+src
src/id_pkg.sv
src/operand_if.sv
src/if_id_reg.sv
src/operand_read.sv
src/inst_decoder.sv
src/branch_unit.sv
src/id_stage.sv
tests/id_checker.sv
tests/tb_id_stage.sv

//--- src/branch_unit.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module branch_unit (
    input  logic [`ID_DATA_W-1:0] pc,
    input  id_pkg::inst_u         inst,
    input  id_pkg::br_kind_t      br_kind,
    operand_if.branch             ops,
    output logic                  br_taken,
    output logic [`ID_DATA_W-1:0] br_target
);

    logic [`ID_DATA_W-1:0] pc_plus_4;
    logic [`ID_DATA_W-1:0] branch_dest;
    logic [`ID_DATA_W-1:0] jump_dest;
    logic                  rs_neg;
    logic                  rs_zero;

    assign pc_plus_4   = pc + `ID_DATA_W'd4;
    assign branch_dest = pc_plus_4
                         + (`ID_DATA_W'(signed'(inst.i.imm)) << `ID_BR_OFS_SHIFT);
    // region bits stay with the delay slot pc
    assign jump_dest   = {pc_plus_4[`ID_DATA_W-1 -: 4], inst.j.index,
                          {`ID_BR_OFS_SHIFT{1'b0}}};

    assign rs_neg  = ops.rs_data[`ID_DATA_W-1];
    assign rs_zero = ops.rs_data == '0;

    always_comb begin
        br_taken  = 1'b0;
        br_target = branch_dest;
        case (br_kind)
            id_pkg::BR_BEQ:  br_taken = ops.rs_data == ops.rt_data;
            id_pkg::BR_BNE:  br_taken = ops.rs_data != ops.rt_data;
            id_pkg::BR_BGEZ: br_taken = !rs_neg;
            id_pkg::BR_BGTZ: br_taken = !rs_neg && !rs_zero;
            id_pkg::BR_BLEZ: br_taken = rs_neg || rs_zero;
            id_pkg::BR_BLTZ: br_taken = rs_neg;
            id_pkg::BR_JUMP: begin
                br_taken  = 1'b1;
                br_target = jump_dest;
            end
            id_pkg::BR_JR: begin
                br_taken  = 1'b1;
                br_target = ops.rs_data;
            end
            default: br_target = '0;
        endcase
    end

endmodule

//--- src/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath and address width
`define ID_DATA_W 32

// register file geometry
`define ID_REG_AW 5
`define ID_NUM_REGS 32

// destination of jal, jalr, bgezal and bltzal
`define ID_LINK_REG 31

// branch offsets and jump indexes count words
`define ID_BR_OFS_SHIFT 2

`endif

//--- src/id_pkg.sv
package id_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fields_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // nine kinds need four bits
    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_JUMP, BR_JR
    } br_kind_t;

endpackage

//--- src/id_stage.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  if_stall,
    input  logic                  id_stall,
    input  logic                  if_valid,
    input  logic [`ID_DATA_W-1:0] if_pc,
    input  id_pkg::inst_u         if_inst,
    input  logic                  ex_we,
    input  logic [`ID_REG_AW-1:0] ex_waddr,
    input  logic [`ID_DATA_W-1:0] ex_wdata,
    input  logic                  ex_ram_read,
    input  logic                  mem_we,
    input  logic [`ID_REG_AW-1:0] mem_waddr,
    input  logic [`ID_DATA_W-1:0] mem_wdata,
    input  logic                  wb_we,
    input  logic [`ID_REG_AW-1:0] wb_waddr,
    input  logic [`ID_DATA_W-1:0] wb_wdata,
    output logic                  id_valid,
    output logic [`ID_DATA_W-1:0] id_pc,
    output id_pkg::inst_u         id_inst,
    output id_pkg::alu_op_t       alu_op,
    output logic [2:0]            alu_src1_sel,
    output logic [3:0]            alu_src2_sel,
    output id_pkg::mem_op_t       mem_op,
    output logic                  data_ram_en,
    output logic                  rf_we,
    output logic [`ID_REG_AW-1:0] rf_waddr,
    output logic                  rf_from_mem,
    output logic [`ID_DATA_W-1:0] rs_data,
    output logic [`ID_DATA_W-1:0] rt_data,
    output logic                  br_taken,
    output logic [`ID_DATA_W-1:0] br_target,
    output logic                  stall_for_load
);

    id_pkg::br_kind_t br_kind;

    operand_if ops ();

    if_id_reg i_if_id_reg (
        .clk, .rst, .flush, .if_stall, .id_stall,
        .if_valid, .if_pc, .if_inst,
        .id_valid, .id_pc, .id_inst
    );

    operand_read i_operand_read (
        .clk, .ops(ops.operand),
        .ex_we, .ex_waddr, .ex_wdata, .ex_ram_read,
        .mem_we, .mem_waddr, .mem_wdata,
        .wb_we, .wb_waddr, .wb_wdata
    );

    inst_decoder i_inst_decoder (
        .inst(id_inst), .ops(ops.decode),
        .alu_op, .alu_src1_sel, .alu_src2_sel, .mem_op,
        .rf_we, .rf_waddr, .rf_from_mem, .br_kind
    );

    branch_unit i_branch_unit (
        .pc(id_pc), .inst(id_inst), .br_kind, .ops(ops.branch),
        .br_taken, .br_target
    );

    // any load or store touches data memory
    assign data_ram_en    = mem_op != id_pkg::MEM_NONE;
    assign rs_data        = ops.rs_data;
    assign rt_data        = ops.rt_data;
    assign stall_for_load = ops.load_hazard;

endmodule

//--- src/if_id_reg.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module if_id_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  if_stall,
    input  logic                  id_stall,
    input  logic                  if_valid,
    input  logic [`ID_DATA_W-1:0] if_pc,
    input  id_pkg::inst_u         if_inst,
    output logic                  id_valid,
    output logic [`ID_DATA_W-1:0] id_pc,
    output id_pkg::inst_u         id_inst
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else if (if_stall && !id_stall) begin
            // fetch stalled, decode moves on: bubble in
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else if (!if_stall) begin
            id_valid <= if_valid;
            id_pc    <= if_pc;
            id_inst  <= if_inst;
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module inst_decoder (
    input  id_pkg::inst_u         inst,
    operand_if.decode             ops,
    output id_pkg::alu_op_t       alu_op,
    output logic [2:0]            alu_src1_sel,
    output logic [3:0]            alu_src2_sel,
    output id_pkg::mem_op_t       mem_op,
    output logic                  rf_we,
    output logic [`ID_REG_AW-1:0] rf_waddr,
    output logic                  rf_from_mem,
    output id_pkg::br_kind_t      br_kind
);

    localparam logic [2:0] SRC1_RS = 3'b001;
    localparam logic [2:0] SRC1_PC = 3'b010;
    localparam logic [2:0] SRC1_SA = 3'b100;

    localparam logic [3:0] SRC2_RT    = 4'b0001;
    localparam logic [3:0] SRC2_SIMM  = 4'b0010;
    localparam logic [3:0] SRC2_EIGHT = 4'b0100;
    localparam logic [3:0] SRC2_ZIMM  = 4'b1000;

    logic dst_rd;
    logic dst_rt;
    logic link;

    assign ops.rs_addr = inst.r.rs;
    assign ops.rt_addr = inst.r.rt;

    always_comb begin
        alu_op       = id_pkg::ALU_NONE;
        alu_src1_sel = '0;
        alu_src2_sel = '0;
        mem_op       = id_pkg::MEM_NONE;
        rf_from_mem  = 1'b0;
        br_kind      = id_pkg::BR_NONE;
        dst_rd       = 1'b0;
        dst_rt       = 1'b0;
        link         = 1'b0;
        // all-zero word is the pipeline nop
        if (inst != '0) begin
            case (inst.r.opcode)
                6'b000000: begin
                    case (inst.r.funct)
                        6'b100000, 6'b100001: alu_op = id_pkg::ALU_ADD;
                        6'b100010, 6'b100011: alu_op = id_pkg::ALU_SUB;
                        6'b101010: alu_op = id_pkg::ALU_SLT;
                        6'b101011: alu_op = id_pkg::ALU_SLTU;
                        6'b100100: alu_op = id_pkg::ALU_AND;
                        6'b100101: alu_op = id_pkg::ALU_OR;
                        6'b100110: alu_op = id_pkg::ALU_XOR;
                        6'b100111: alu_op = id_pkg::ALU_NOR;
                        6'b000000, 6'b000100: alu_op = id_pkg::ALU_SLL;
                        6'b000010, 6'b000110: alu_op = id_pkg::ALU_SRL;
                        6'b000011, 6'b000111: alu_op = id_pkg::ALU_SRA;
                        6'b001000: br_kind = id_pkg::BR_JR;
                        6'b001001: begin
                            br_kind = id_pkg::BR_JR;
                            link    = 1'b1;
                        end
                        default: ;
                    endcase
                    if (alu_op != id_pkg::ALU_NONE) begin
                        // sll, srl, sra take the shift amount from sa
                        alu_src1_sel = (inst.r.funct[5:2] == 4'b0000) ? SRC1_SA : SRC1_RS;
                        alu_src2_sel = SRC2_RT;
                        dst_rd       = 1'b1;
                    end
                end
                6'b000001: begin
                    case (inst.r.rt)
                        5'b00000: br_kind = id_pkg::BR_BLTZ;
                        5'b00001: br_kind = id_pkg::BR_BGEZ;
                        5'b10000: br_kind = id_pkg::BR_BLTZ;
                        5'b10001: br_kind = id_pkg::BR_BGEZ;
                        default: ;
                    endcase
                    link = br_kind != id_pkg::BR_NONE && inst.r.rt[4];
                end
                6'b000010: br_kind = id_pkg::BR_JUMP;
                6'b000011: begin
                    br_kind = id_pkg::BR_JUMP;
                    link    = 1'b1;
                end
                6'b000100: br_kind = id_pkg::BR_BEQ;
                6'b000101: br_kind = id_pkg::BR_BNE;
                6'b000110: br_kind = id_pkg::BR_BLEZ;
                6'b000111: br_kind = id_pkg::BR_BGTZ;
                6'b001000, 6'b001001, 6'b001010, 6'b001011,
                6'b001100, 6'b001101, 6'b001110, 6'b001111: begin
                    case (inst.i.opcode[2:0])
                        3'b000, 3'b001: alu_op = id_pkg::ALU_ADD;
                        3'b010: alu_op = id_pkg::ALU_SLT;
                        3'b011: alu_op = id_pkg::ALU_SLTU;
                        3'b100: alu_op = id_pkg::ALU_AND;
                        3'b101: alu_op = id_pkg::ALU_OR;
                        3'b110: alu_op = id_pkg::ALU_XOR;
                        default: alu_op = id_pkg::ALU_LUI;
                    endcase
                    // logical immediates are zero-extended, lui ignores rs
                    alu_src1_sel = (alu_op == id_pkg::ALU_LUI) ? 3'b000 : SRC1_RS;
                    alu_src2_sel = (inst.i.opcode[2] && !(&inst.i.opcode[1:0])) ?
                                   SRC2_ZIMM : SRC2_SIMM;
                    dst_rt       = 1'b1;
                end
                6'b100000: mem_op = id_pkg::MEM_LB;
                6'b100001: mem_op = id_pkg::MEM_LH;
                6'b100011: mem_op = id_pkg::MEM_LW;
                6'b100100: mem_op = id_pkg::MEM_LBU;
                6'b100101: mem_op = id_pkg::MEM_LHU;
                6'b101000: mem_op = id_pkg::MEM_SB;
                6'b101001: mem_op = id_pkg::MEM_SH;
                6'b101011: mem_op = id_pkg::MEM_SW;
                default: ;
            endcase
        end
        if (mem_op != id_pkg::MEM_NONE) begin
            // address is base plus offset
            alu_op       = id_pkg::ALU_ADD;
            alu_src1_sel = SRC1_RS;
            alu_src2_sel = SRC2_SIMM;
            rf_from_mem  = !inst.i.opcode[3];
            dst_rt       = !inst.i.opcode[3];
        end
        if (link) begin
            // return address pc + 8 goes to the link register
            alu_op       = id_pkg::ALU_ADD;
            alu_src1_sel = SRC1_PC;
            alu_src2_sel = SRC2_EIGHT;
        end
    end

    always_comb begin
        if (link) begin
            rf_waddr = `ID_REG_AW'(`ID_LINK_REG);
        end else if (dst_rt) begin
            rf_waddr = inst.i.rt;
        end else if (dst_rd) begin
            rf_waddr = inst.r.rd;
        end else begin
            rf_waddr = '0;
        end
    end

    // r0 destination means no write at all
    assign rf_we = (link || dst_rt || dst_rd) && rf_waddr != '0;

endmodule

//--- src/operand_if.sv
`timescale 1ns/10ps
`include "id_defines.svh"

interface operand_if;

    logic [`ID_REG_AW-1:0] rs_addr;
    logic [`ID_REG_AW-1:0] rt_addr;
    logic [`ID_DATA_W-1:0] rs_data;
    logic [`ID_DATA_W-1:0] rt_data;
    logic                  load_hazard;

    modport decode (output rs_addr, rt_addr);

    modport operand (input rs_addr, rt_addr, output rs_data, rt_data, load_hazard);

    // branch compare only watches the resolved operands
    modport branch (input rs_data, rt_data);

endinterface

//--- src/operand_read.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module operand_read (
    input  logic                  clk,
    operand_if.operand            ops,
    input  logic                  ex_we,
    input  logic [`ID_REG_AW-1:0] ex_waddr,
    input  logic [`ID_DATA_W-1:0] ex_wdata,
    input  logic                  ex_ram_read,
    input  logic                  mem_we,
    input  logic [`ID_REG_AW-1:0] mem_waddr,
    input  logic [`ID_DATA_W-1:0] mem_wdata,
    input  logic                  wb_we,
    input  logic [`ID_REG_AW-1:0] wb_waddr,
    input  logic [`ID_DATA_W-1:0] wb_wdata
);

    logic [`ID_DATA_W-1:0] regs [`ID_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    // youngest producer wins, r0 is hardwired
    function automatic logic [`ID_DATA_W-1:0] resolve(input logic [`ID_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (ex_we && ex_waddr == addr) begin
            return ex_wdata;
        end
        if (mem_we && mem_waddr == addr) begin
            return mem_wdata;
        end
        if (wb_we && wb_waddr == addr) begin
            return wb_wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        ops.rs_data = resolve(ops.rs_addr);
        ops.rt_data = resolve(ops.rt_addr);
    end

    // load result not ready until after MEM
    assign ops.load_hazard = ex_ram_read && ex_waddr != '0
                             && (ex_waddr == ops.rs_addr || ex_waddr == ops.rt_addr);

endmodule

//--- tests/id_checker.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module id_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  flush,
    input logic                  if_stall,
    input logic                  id_stall,
    input logic                  if_valid,
    input logic [`ID_DATA_W-1:0] if_pc,
    input id_pkg::inst_u         if_inst,
    input logic                  ex_we,
    input logic [`ID_REG_AW-1:0] ex_waddr,
    input logic [`ID_DATA_W-1:0] ex_wdata,
    input logic                  ex_ram_read,
    input logic                  mem_we,
    input logic [`ID_REG_AW-1:0] mem_waddr,
    input logic [`ID_DATA_W-1:0] mem_wdata,
    input logic                  wb_we,
    input logic [`ID_REG_AW-1:0] wb_waddr,
    input logic [`ID_DATA_W-1:0] wb_wdata,
    input logic                  id_valid,
    input logic [`ID_DATA_W-1:0] id_pc,
    input id_pkg::inst_u         id_inst,
    input id_pkg::alu_op_t       alu_op,
    input logic [2:0]            alu_src1_sel,
    input logic [3:0]            alu_src2_sel,
    input id_pkg::mem_op_t       mem_op,
    input logic                  data_ram_en,
    input logic                  rf_we,
    input logic [`ID_REG_AW-1:0] rf_waddr,
    input logic                  rf_from_mem,
    input logic [`ID_DATA_W-1:0] rs_data,
    input logic [`ID_DATA_W-1:0] rt_data,
    input logic                  br_taken,
    input logic [`ID_DATA_W-1:0] br_target,
    input logic                  stall_for_load
);

    int errors = 0;

    logic [`ID_DATA_W-1:0] shadow [`ID_NUM_REGS];
    logic                  exp_valid;
    logic [`ID_DATA_W-1:0] exp_pc;
    id_pkg::inst_u         exp_inst;
    logic [`ID_DATA_W-1:0] exp_rs;
    logic [`ID_DATA_W-1:0] exp_rt;
    logic [`ID_REG_AW-1:0] exp_waddr;
    logic                  exp_hazard;
    id_pkg::alu_op_t       exp_alu;
    logic [2:0]            exp_src1;
    logic [3:0]            exp_src2;
    id_pkg::mem_op_t       exp_mem_op;
    logic                  exp_link;
    logic                  exp_writes;
    logic                  exp_we;
    logic                  exp_from_mem;
    logic                  exp_taken;
    logic [`ID_DATA_W-1:0] exp_target;
    logic [`ID_DATA_W-1:0] pc_next;
    logic [`ID_DATA_W-1:0] ofs_target;

    always_ff @(posedge clk) begin
        if (wb_we) begin
            shadow[wb_waddr] <= wb_wdata;
        end
    end

    // reference IF/ID register
    always_ff @(posedge clk) begin
        if (rst || flush || (if_stall && !id_stall)) begin
            exp_valid <= 1'b0;
            exp_pc    <= '0;
            exp_inst  <= '0;
        end else if (!if_stall) begin
            exp_valid <= if_valid;
            exp_pc    <= if_pc;
            exp_inst  <= if_inst;
        end
    end

    function automatic logic [`ID_DATA_W-1:0] expected_operand(
        input logic [`ID_REG_AW-1:0] src
    );
        logic [`ID_DATA_W-1:0] val;
        if (src == '0) begin
            val = '0;
        end else if (ex_we && ex_waddr == src) begin
            val = ex_wdata;
        end else if (mem_we && mem_waddr == src) begin
            val = mem_wdata;
        end else if (wb_we && wb_waddr == src) begin
            val = wb_wdata;
        end else begin
            val = shadow[src];
        end
        return val;
    endfunction

    always_comb begin
        exp_rs     = expected_operand(id_inst.r.rs);
        exp_rt     = expected_operand(id_inst.r.rt);
        exp_hazard = ex_ram_read && ex_waddr != '0
                     && (ex_waddr == id_inst.r.rs || ex_waddr == id_inst.r.rt);
    end

    // expected controls per instruction class
    always_comb begin
        exp_alu      = id_pkg::ALU_NONE;
        exp_src1     = 3'b000;
        exp_src2     = 4'b0000;
        exp_mem_op   = id_pkg::MEM_NONE;
        exp_writes   = 1'b0;
        exp_from_mem = 1'b0;
        exp_link     = id_inst.r.opcode == 6'h03
                       || (id_inst.r.opcode == 6'h00 && id_inst.r.funct == 6'h09)
                       || (id_inst.r.opcode == 6'h01 && id_inst.r.rt inside {5'h10, 5'h11});
        case (id_inst.r.opcode)
            6'h00: begin
                case (id_inst.r.funct)
                    6'h20, 6'h21: exp_alu = id_pkg::ALU_ADD;
                    6'h22, 6'h23: exp_alu = id_pkg::ALU_SUB;
                    6'h2a: exp_alu = id_pkg::ALU_SLT;
                    6'h2b: exp_alu = id_pkg::ALU_SLTU;
                    6'h24: exp_alu = id_pkg::ALU_AND;
                    6'h25: exp_alu = id_pkg::ALU_OR;
                    6'h26: exp_alu = id_pkg::ALU_XOR;
                    6'h27: exp_alu = id_pkg::ALU_NOR;
                    6'h00, 6'h04: exp_alu = id_pkg::ALU_SLL;
                    6'h02, 6'h06: exp_alu = id_pkg::ALU_SRL;
                    6'h03, 6'h07: exp_alu = id_pkg::ALU_SRA;
                    default: ;
                endcase
                // the all-zero nop decodes to nothing
                if (id_inst == '0) begin
                    exp_alu = id_pkg::ALU_NONE;
                end
                if (exp_alu != id_pkg::ALU_NONE) begin
                    exp_src1   = (id_inst.r.funct inside {6'h00, 6'h02, 6'h03}) ?
                                 3'b100 : 3'b001;
                    exp_src2   = 4'b0001;
                    exp_writes = 1'b1;
                end
            end
            6'h08, 6'h09: exp_alu = id_pkg::ALU_ADD;
            6'h0a: exp_alu = id_pkg::ALU_SLT;
            6'h0b: exp_alu = id_pkg::ALU_SLTU;
            6'h0c: exp_alu = id_pkg::ALU_AND;
            6'h0d: exp_alu = id_pkg::ALU_OR;
            6'h0e: exp_alu = id_pkg::ALU_XOR;
            6'h0f: exp_alu = id_pkg::ALU_LUI;
            6'h20: exp_mem_op = id_pkg::MEM_LB;
            6'h21: exp_mem_op = id_pkg::MEM_LH;
            6'h23: exp_mem_op = id_pkg::MEM_LW;
            6'h24: exp_mem_op = id_pkg::MEM_LBU;
            6'h25: exp_mem_op = id_pkg::MEM_LHU;
            6'h28: exp_mem_op = id_pkg::MEM_SB;
            6'h29: exp_mem_op = id_pkg::MEM_SH;
            6'h2b: exp_mem_op = id_pkg::MEM_SW;
            default: ;
        endcase
        if (id_inst.r.opcode inside {[6'h08:6'h0f]}) begin
            // andi, ori and xori zero-extend, lui has no register source
            exp_src1   = (id_inst.r.opcode == 6'h0f) ? 3'b000 : 3'b001;
            exp_src2   = (id_inst.r.opcode inside {6'h0c, 6'h0d, 6'h0e}) ? 4'b1000 : 4'b0010;
            exp_writes = 1'b1;
        end
        if (exp_mem_op != id_pkg::MEM_NONE) begin
            exp_alu      = id_pkg::ALU_ADD;
            exp_src1     = 3'b001;
            exp_src2     = 4'b0010;
            exp_writes   = id_inst.r.opcode < 6'h28;
            exp_from_mem = exp_writes;
        end
        if (exp_link) begin
            exp_alu    = id_pkg::ALU_ADD;
            exp_src1   = 3'b010;
            exp_src2   = 4'b0100;
            exp_writes = 1'b1;
        end
        if (exp_link) begin
            exp_waddr = `ID_REG_AW'(`ID_LINK_REG);
        end else if (id_inst.r.opcode == 6'h00) begin
            exp_waddr = id_inst.r.rd;
        end else begin
            exp_waddr = id_inst.i.rt;
        end
        exp_we = exp_writes && exp_waddr != '0;
    end

    always_comb begin
        pc_next    = id_pc + 32'd4;
        ofs_target = pc_next + {{(`ID_DATA_W - 16 - `ID_BR_OFS_SHIFT){id_inst.i.imm[15]}},
                                id_inst.i.imm, {`ID_BR_OFS_SHIFT{1'b0}}};
        exp_taken  = 1'b0;
        exp_target = '0;
        case (id_inst.r.opcode)
            6'h00: begin
                if (id_inst.r.funct inside {6'h08, 6'h09}) begin
                    exp_taken  = 1'b1;
                    exp_target = exp_rs;
                end
            end
            6'h01: begin
                if (id_inst.r.rt inside {5'h00, 5'h01, 5'h10, 5'h11}) begin
                    exp_target = ofs_target;
                    exp_taken  = id_inst.r.rt[0] ? $signed(exp_rs) >= 0 : $signed(exp_rs) < 0;
                end
            end
            6'h02, 6'h03: begin
                exp_taken  = 1'b1;
                exp_target = {pc_next[31:28], id_inst.j.index, {`ID_BR_OFS_SHIFT{1'b0}}};
            end
            6'h04: begin
                exp_target = ofs_target;
                exp_taken  = exp_rs == exp_rt;
            end
            6'h05: begin
                exp_target = ofs_target;
                exp_taken  = exp_rs != exp_rt;
            end
            6'h06: begin
                exp_target = ofs_target;
                exp_taken  = $signed(exp_rs) <= 0;
            end
            6'h07: begin
                exp_target = ofs_target;
                exp_taken  = $signed(exp_rs) > 0;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) $fell(rst) |->
                     !rf_we && !data_ram_en && !br_taken && !stall_for_load)
        else begin
            $error("[ERROR] rf_we/data_ram_en/br_taken/stall_for_load expected 0 actual %h/%h/%h/%h",
                   $sampled(rf_we), $sampled(data_ram_en), $sampled(br_taken),
                   $sampled(stall_for_load));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     id_valid == exp_valid && id_pc == exp_pc && id_inst == exp_inst)
        else begin
            $error("[ERROR] id_valid/id_pc/id_inst expected %h/%h/%h actual %h/%h/%h",
                   $sampled(exp_valid), $sampled(exp_pc), $sampled(exp_inst),
                   $sampled(id_valid), $sampled(id_pc), $sampled(id_inst));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) rs_data == exp_rs)
        else begin
            $error("[ERROR] rs_data expected %h actual %h", $sampled(exp_rs), $sampled(rs_data));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) rt_data == exp_rt)
        else begin
            $error("[ERROR] rt_data expected %h actual %h", $sampled(exp_rt), $sampled(rt_data));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) stall_for_load == exp_hazard)
        else begin
            $error("[ERROR] stall_for_load expected %h actual %h", $sampled(exp_hazard),
                   $sampled(stall_for_load));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     alu_op == exp_alu && alu_src1_sel == exp_src1 && alu_src2_sel == exp_src2)
        else begin
            $error("[ERROR] alu_op/alu_src1_sel/alu_src2_sel expected %h/%h/%h actual %h/%h/%h",
                   $sampled(exp_alu), $sampled(exp_src1), $sampled(exp_src2),
                   $sampled(alu_op), $sampled(alu_src1_sel), $sampled(alu_src2_sel));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     rf_we == exp_we && rf_from_mem == exp_from_mem)
        else begin
            $error("[ERROR] rf_we/rf_from_mem expected %h/%h actual %h/%h", $sampled(exp_we),
                   $sampled(exp_from_mem), $sampled(rf_we), $sampled(rf_from_mem));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) rf_we |-> rf_waddr == exp_waddr)
        else begin
            $error("[ERROR] rf_waddr expected %h actual %h", $sampled(exp_waddr),
                   $sampled(rf_waddr));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     mem_op == exp_mem_op && data_ram_en == (exp_mem_op != id_pkg::MEM_NONE))
        else begin
            $error("[ERROR] mem_op/data_ram_en expected %h/%h actual %h/%h",
                   $sampled(exp_mem_op), $sampled(exp_mem_op != id_pkg::MEM_NONE),
                   $sampled(mem_op), $sampled(data_ram_en));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     br_taken == exp_taken && br_target == exp_target)
        else begin
            $error("[ERROR] br_taken/br_target expected %h/%h actual %h/%h", $sampled(exp_taken),
                   $sampled(exp_target), $sampled(br_taken), $sampled(br_target));
            errors++;
        end

endmodule

//--- tests/tb_id_stage.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module tb_id_stage;

    localparam int RESET_CYCLES   = 10;
    localparam int PRELOAD_CYCLES = `ID_NUM_REGS - 1;
    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = (RESET_CYCLES + PRELOAD_CYCLES + RUN_CYCLES) * 5 / 4;

    localparam logic [5:0] R_FUNCTS [18] = '{
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a,
        6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09
    };
    localparam logic [5:0] IJ_OPCODES [22] = '{
        6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c,
        6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b
    };
    localparam logic [4:0] REGIMM_RT [4] = '{5'h00, 5'h01, 5'h10, 5'h11};

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  flush;
    logic                  if_stall;
    logic                  id_stall;
    logic                  if_valid;
    logic [`ID_DATA_W-1:0] if_pc;
    id_pkg::inst_u         if_inst;
    logic                  ex_we;
    logic [`ID_REG_AW-1:0] ex_waddr;
    logic [`ID_DATA_W-1:0] ex_wdata;
    logic                  ex_ram_read;
    logic                  mem_we;
    logic [`ID_REG_AW-1:0] mem_waddr;
    logic [`ID_DATA_W-1:0] mem_wdata;
    logic                  wb_we;
    logic [`ID_REG_AW-1:0] wb_waddr;
    logic [`ID_DATA_W-1:0] wb_wdata;
    logic                  id_valid;
    logic [`ID_DATA_W-1:0] id_pc;
    id_pkg::inst_u         id_inst;
    id_pkg::alu_op_t       alu_op;
    logic [2:0]            alu_src1_sel;
    logic [3:0]            alu_src2_sel;
    id_pkg::mem_op_t       mem_op;
    logic                  data_ram_en;
    logic                  rf_we;
    logic [`ID_REG_AW-1:0] rf_waddr;
    logic                  rf_from_mem;
    logic [`ID_DATA_W-1:0] rs_data;
    logic [`ID_DATA_W-1:0] rt_data;
    logic                  br_taken;
    logic [`ID_DATA_W-1:0] br_target;
    logic                  stall_for_load;

    int          cycle_count = 0;
    int          check_errors;

    id_stage i_dut (.*);

    bind id_stage id_checker i_checker (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] random_instruction();
        logic [31:0] word;
        int          kind;
        word = $urandom;
        kind = $urandom_range(0, 9);
        // small register numbers make forwarding hits common
        word[25:21] = 5'($urandom_range(0, 7));
        word[20:16] = 5'($urandom_range(0, 7));
        if (kind < 4) begin
            word[31:26] = 6'h00;
            word[5:0]   = R_FUNCTS[$urandom_range(0, 17)];
        end else if (kind < 8) begin
            word[31:26] = IJ_OPCODES[$urandom_range(0, 21)];
        end else if (kind == 8) begin
            word[31:26] = 6'h01;
            word[20:16] = REGIMM_RT[$urandom_range(0, 3)];
        end
        return word;
    endfunction

    task automatic drive_random_cycle();
        if_inst     = random_instruction();
        if_valid    = $urandom_range(0, 7) != 0;
        if_pc       = $urandom & ~32'h3;
        flush       = $urandom_range(0, 19) == 0;
        if_stall    = $urandom_range(0, 9) == 0;
        id_stall    = $urandom_range(0, 9) == 0;
        ex_we       = 1'($urandom_range(0, 1));
        ex_waddr    = 5'($urandom_range(0, 7));
        ex_wdata    = $urandom;
        ex_ram_read = $urandom_range(0, 3) == 0;
        mem_we      = 1'($urandom_range(0, 1));
        mem_waddr   = 5'($urandom_range(0, 7));
        mem_wdata   = $urandom;
        wb_we       = 1'($urandom_range(0, 1));
        wb_waddr    = 5'($urandom_range(0, 15));
        wb_wdata    = $urandom;
    endtask

    initial begin
        void'($urandom(32'hf931_2fcd));
        rst         = 1'b1;
        flush       = 1'b0;
        if_stall    = 1'b0;
        id_stall    = 1'b0;
        // lw r3 from r2 with a load of r2 in EX, only reset keeps it out
        if_valid    = 1'b1;
        if_pc       = '0;
        if_inst     = 32'h8c43_0000;
        ex_we       = 1'b0;
        ex_waddr    = 5'd2;
        ex_wdata    = '0;
        ex_ram_read = 1'b1;
        mem_we      = 1'b0;
        mem_waddr   = '0;
        mem_wdata   = '0;
        wb_we       = 1'b0;
        wb_waddr    = '0;
        wb_wdata    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst     = 1'b0;
        if_inst = '0;
        // fill every register so no read returns an unwritten entry
        for (int r = 1; r < `ID_NUM_REGS; r++) begin
            wb_we    = 1'b1;
            wb_waddr = 5'(r);
            wb_wdata = $urandom;
            @(negedge clk);
        end
        repeat (RUN_CYCLES) begin
            drive_random_cycle();
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        check_errors = i_dut.i_checker.errors;
        $display("run complete: %0d assertion errors", check_errors);
        if (check_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
